/* design/spu_isa_pkg.sv */
`default_nettype none

package spu_isa_pkg;

    // kept odd pipe instructions, the bubble encodes as zero
    typedef enum logic [0:4] {
        NO_OPERATION_LOAD,
        SHIFT_LEFT_QUADWORD_BY_BITS,
        SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE,
        SHIFT_LEFT_QUADWORD_BY_BYTES,
        SHIFT_LEFT_QUADWORD_BY_BYTES_IMMEDIATE,
        SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT,
        ROTATE_QUADWORD_BY_BITS,
        ROTATE_QUADWORD_BY_BITS_IMMEDIATE,
        ROTATE_QUADWORD_BY_BYTES,
        ROTATE_QUADWORD_BY_BYTES_IMMEDIATE,
        ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT,
        GATHER_BITS_FROM_BYTES,
        GATHER_BITS_FROM_HALFWORDS,
        GATHER_BITS_FROM_WORDS,
        BRANCH_RELATIVE,
        BRANCH_ABSOLUTE,
        BRANCH_RELATIVE_AND_SET_LINK,
        BRANCH_ABSOLUTE_AND_SET_LINK,
        BRANCH_IF_NOT_ZERO_WORD,
        BRANCH_IF_ZERO_WORD,
        BRANCH_IF_NOT_ZERO_HALFWORD,
        BRANCH_IF_ZERO_HALFWORD
    } opcode_t;

    typedef logic [0:2] unit_id_t;
    typedef logic [0:3] latency_t;

    localparam unit_id_t UNIT_NONE    = 3'd0;
    localparam unit_id_t UNIT_PERMUTE = 3'd5;
    localparam unit_id_t UNIT_BRANCH  = 3'd7;

    localparam latency_t PERMUTE_LATENCY = 4'd4;
    localparam latency_t BRANCH_LATENCY  = 4'd1;

    // local store is 256 KB
    localparam logic [0:31] LSLR = 32'h0003_FFFF;

    localparam int unsigned PC_INCREMENT = 4;

endpackage

`default_nettype wire

/* design/odd_pipe_pkg.sv */
`default_nettype none

package odd_pipe_pkg;

    // big-endian numbering throughout, bit 0 is the msb
    typedef logic [0:127] quad_t;
    typedef logic [0:31]  word_t;

    typedef logic [0:6]   reg_addr_t;
    typedef logic [0:6]   imm7_t;
    typedef logic [0:15]  imm16_t;

    // widest count is the 5 bit byte shift
    typedef logic [0:4]   shift_count_t;

    localparam int BYTE_BITS     = 8;
    localparam int HALFWORD_BITS = 16;
    localparam int WORD_BITS     = 32;

    // result records spend this many cycles in the forwarding pipe
    localparam int FORWARD_STAGES = 7;

endpackage

`default_nettype wire

/* design/issue_stage.sv */
`default_nettype none

module issue_stage
    import spu_isa_pkg::*;
    import odd_pipe_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire opcode_t   op_code,
    input  wire quad_t     ra,
    input  wire quad_t     rb,
    input  wire quad_t     rc,
    input  wire reg_addr_t rt_address,
    input  wire imm7_t     i7,
    input  wire imm16_t    i16,
    input  wire word_t     pc_input,
    output opcode_t        op_q,
    output quad_t          ra_q,
    output quad_t          rb_q,
    output quad_t          rc_q,
    output reg_addr_t      rt_address_q,
    output imm7_t          i7_q,
    output imm16_t         i16_q,
    output word_t          pc_q,
    output unit_id_t       unit_id,
    output logic           wrt_en,
    output latency_t       unit_latency
);

    always_ff @(posedge clock)
    begin
        if (reset)
            op_q <= NO_OPERATION_LOAD;
        else
            op_q <= op_code;
    end

    // operand payload, only meaningful with the latched opcode
    always_ff @(posedge clock)
    begin
        ra_q         <= ra;
        rb_q         <= rb;
        rc_q         <= rc;
        rt_address_q <= rt_address;
        i7_q         <= i7;
        i16_q        <= i16;
        pc_q         <= pc_input;
    end

    always_comb
    begin
        unit_id      = UNIT_NONE;
        wrt_en       = 1'b0;
        unit_latency = '0;
        case (op_q)
            SHIFT_LEFT_QUADWORD_BY_BITS,
            SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE,
            SHIFT_LEFT_QUADWORD_BY_BYTES,
            SHIFT_LEFT_QUADWORD_BY_BYTES_IMMEDIATE,
            SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT,
            ROTATE_QUADWORD_BY_BITS,
            ROTATE_QUADWORD_BY_BITS_IMMEDIATE,
            ROTATE_QUADWORD_BY_BYTES,
            ROTATE_QUADWORD_BY_BYTES_IMMEDIATE,
            ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT,
            GATHER_BITS_FROM_BYTES,
            GATHER_BITS_FROM_HALFWORDS,
            GATHER_BITS_FROM_WORDS:
            begin
                unit_id      = UNIT_PERMUTE;
                wrt_en       = 1'b1;
                unit_latency = PERMUTE_LATENCY;
            end
            BRANCH_RELATIVE_AND_SET_LINK,
            BRANCH_ABSOLUTE_AND_SET_LINK:
            begin
                unit_id      = UNIT_BRANCH;
                wrt_en       = 1'b1;
                unit_latency = BRANCH_LATENCY;
            end
            BRANCH_RELATIVE,
            BRANCH_ABSOLUTE,
            BRANCH_IF_NOT_ZERO_WORD,
            BRANCH_IF_ZERO_WORD,
            BRANCH_IF_NOT_ZERO_HALFWORD,
            BRANCH_IF_ZERO_HALFWORD:
            begin
                unit_id      = UNIT_BRANCH;
                unit_latency = BRANCH_LATENCY;
            end
            default:
            begin
            end
        endcase
    end

    a_op_known: assert property (@(posedge clock) disable iff (reset) !$isunknown(op_q))
        else $error("latched opcode is unknown");

endmodule

`default_nettype wire

/* design/permute_unit.sv */
`default_nettype none

module permute_unit
    import spu_isa_pkg::*;
    import odd_pipe_pkg::*;
(
    input  wire opcode_t op_q,
    input  wire quad_t   ra_q,
    input  wire quad_t   rb_q,
    input  wire imm7_t   i7_q,
    output quad_t        permute_result
);

    shift_count_t count;
    logic         shift_op;
    logic         byte_mode;
    logic         rotate;
    logic [0:7]   amount;
    quad_t        shifted;
    quad_t        wrapped;

    always_comb
    begin
        count     = '0;
        shift_op  = 1'b1;
        byte_mode = 1'b0;
        rotate    = 1'b0;
        case (op_q)
            SHIFT_LEFT_QUADWORD_BY_BITS:
                count = {2'b00, rb_q[29:31]};
            SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE:
                count = {2'b00, i7_q[4:6]};
            SHIFT_LEFT_QUADWORD_BY_BYTES:
            begin
                count     = rb_q[27:31];
                byte_mode = 1'b1;
            end
            SHIFT_LEFT_QUADWORD_BY_BYTES_IMMEDIATE:
            begin
                count     = i7_q[2:6];
                byte_mode = 1'b1;
            end
            SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT:
            begin
                count     = rb_q[24:28];
                byte_mode = 1'b1;
            end
            ROTATE_QUADWORD_BY_BITS:
            begin
                count  = {2'b00, rb_q[29:31]};
                rotate = 1'b1;
            end
            ROTATE_QUADWORD_BY_BITS_IMMEDIATE:
            begin
                count  = {2'b00, i7_q[4:6]};
                rotate = 1'b1;
            end
            ROTATE_QUADWORD_BY_BYTES:
            begin
                count     = {1'b0, rb_q[28:31]};
                byte_mode = 1'b1;
                rotate    = 1'b1;
            end
            ROTATE_QUADWORD_BY_BYTES_IMMEDIATE:
            begin
                count     = {1'b0, i7_q[3:6]};
                byte_mode = 1'b1;
                rotate    = 1'b1;
            end
            ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT:
            begin
                // byte count from rb bits 24 to 28, taken modulo 16
                count     = {1'b0, rb_q[25:28]};
                byte_mode = 1'b1;
                rotate    = 1'b1;
            end
            default:
                shift_op = 1'b0;
        endcase
    end

    // 16 or more bytes shifts everything out
    assign amount  = byte_mode ? {count, 3'b000} : {3'b000, count};
    assign shifted = ra_q << amount;
    assign wrapped = ra_q >> ($bits(quad_t) - amount);

    always_comb
    begin
        permute_result = '0;
        case (op_q)
            GATHER_BITS_FROM_BYTES:
                for (int j = 0; j < $bits(quad_t) / BYTE_BITS; j++)
                    permute_result[16 + j] = ra_q[j * BYTE_BITS + BYTE_BITS - 1];
            GATHER_BITS_FROM_HALFWORDS:
                for (int j = 0; j < $bits(quad_t) / HALFWORD_BITS; j++)
                    permute_result[24 + j] = ra_q[j * HALFWORD_BITS + HALFWORD_BITS - 1];
            GATHER_BITS_FROM_WORDS:
                for (int j = 0; j < $bits(quad_t) / WORD_BITS; j++)
                    permute_result[28 + j] = ra_q[j * WORD_BITS + WORD_BITS - 1];
            default:
            begin
                if (shift_op)
                    permute_result = rotate ? (shifted | wrapped) : shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`default_nettype none

module branch_unit
    import spu_isa_pkg::*;
    import odd_pipe_pkg::*;
(
    input  wire opcode_t op_q,
    input  wire quad_t   rc_q,
    input  wire imm16_t  i16_q,
    input  wire word_t   pc_q,
    output word_t        pc_output,
    output logic         pc_redirect,
    output quad_t        link_result
);

    // local store limit plus word alignment
    localparam word_t PC_MASK = LSLR & 32'hFFFF_FFFC;

    word_t offset;
    word_t next_pc;
    word_t target_rel;
    word_t target_abs;
    logic  word_zero;
    logic  half_zero;

    // i16 is a word offset
    assign offset = {{(WORD_BITS - $bits(imm16_t) - 2){i16_q[0]}}, i16_q, 2'b00};

    assign next_pc    = word_t'(pc_q + PC_INCREMENT) & PC_MASK;
    assign target_rel = word_t'(pc_q + offset) & PC_MASK;
    assign target_abs = offset & PC_MASK;

    // tested value sits in the preferred slot of rc
    assign word_zero = (rc_q[0:31] == '0);
    assign half_zero = (rc_q[16:31] == '0);

    assign link_result = {next_pc, {($bits(quad_t) - WORD_BITS){1'b0}}};

    always_comb
    begin
        pc_output   = '0;
        pc_redirect = 1'b1;
        case (op_q)
            BRANCH_RELATIVE,
            BRANCH_RELATIVE_AND_SET_LINK:
                pc_output = target_rel;
            BRANCH_ABSOLUTE,
            BRANCH_ABSOLUTE_AND_SET_LINK:
                pc_output = target_abs;
            BRANCH_IF_NOT_ZERO_WORD:
                pc_output = word_zero ? next_pc : target_rel;
            BRANCH_IF_ZERO_WORD:
                pc_output = word_zero ? target_rel : next_pc;
            BRANCH_IF_NOT_ZERO_HALFWORD:
                pc_output = half_zero ? next_pc : target_rel;
            BRANCH_IF_ZERO_HALFWORD:
                pc_output = half_zero ? target_rel : next_pc;
            default:
                pc_redirect = 1'b0;
        endcase
    end

    // fetch only takes word aligned targets
    always_comb
    begin
        if (pc_redirect)
        begin
            a_target_aligned: assert (pc_output[30:31] == 2'b00)
                else $error("branch target is not word aligned");
        end
    end

endmodule

`default_nettype wire

/* design/result_pipe.sv */
`default_nettype none

module result_pipe
    import odd_pipe_pkg::*;
#(
    parameter type unit_id_type = logic,
    parameter type latency_type = logic
)
(
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire unit_id_type in_unit_id,
    input  wire quad_t       in_rt_value,
    input  wire logic        in_wrt_en,
    input  wire reg_addr_t   in_rt_address,
    input  wire latency_type in_latency,
    output unit_id_type      out_unit_id,
    output quad_t            out_rt_value,
    output logic             out_wrt_en,
    output reg_addr_t        out_rt_address,
    output latency_type      out_latency
);

    unit_id_type unit_id_st    [FORWARD_STAGES];
    quad_t       rt_value_st   [FORWARD_STAGES];
    logic        wrt_en_st     [FORWARD_STAGES];
    reg_addr_t   rt_address_st [FORWARD_STAGES];
    latency_type latency_st    [FORWARD_STAGES];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int s = 0; s < FORWARD_STAGES; s++)
            begin
                unit_id_st[s]    <= '0;
                rt_value_st[s]   <= '0;
                wrt_en_st[s]     <= 1'b0;
                rt_address_st[s] <= '0;
                latency_st[s]    <= '0;
            end
        end
        else
        begin
            unit_id_st[0]    <= in_unit_id;
            rt_value_st[0]   <= in_rt_value;
            wrt_en_st[0]     <= in_wrt_en;
            rt_address_st[0] <= in_rt_address;
            latency_st[0]    <= in_latency;
            for (int s = 1; s < FORWARD_STAGES; s++)
            begin
                unit_id_st[s]    <= unit_id_st[s - 1];
                rt_value_st[s]   <= rt_value_st[s - 1];
                wrt_en_st[s]     <= wrt_en_st[s - 1];
                rt_address_st[s] <= rt_address_st[s - 1];
                latency_st[s]    <= latency_st[s - 1];
            end
        end
    end

    assign out_unit_id    = unit_id_st[FORWARD_STAGES - 1];
    assign out_rt_value   = rt_value_st[FORWARD_STAGES - 1];
    assign out_wrt_en     = wrt_en_st[FORWARD_STAGES - 1];
    assign out_rt_address = rt_address_st[FORWARD_STAGES - 1];
    assign out_latency    = latency_st[FORWARD_STAGES - 1];

    // a register write must always come from a real unit
    a_wrt_has_unit: assert property (@(posedge clock) disable iff (reset)
        out_wrt_en |-> (out_unit_id != '0))
        else $error("write enable on a record without a unit");

endmodule

`default_nettype wire

/* design/odd_pipe.sv */
`default_nettype none

module odd_pipe
    import spu_isa_pkg::*;
    import odd_pipe_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire opcode_t   op_code,
    input  wire quad_t     ra,
    input  wire quad_t     rb,
    input  wire quad_t     rc,
    input  wire reg_addr_t rt_address,
    input  wire imm7_t     i7,
    input  wire imm16_t    i16,
    input  wire word_t     pc_input,
    output word_t          pc_output,
    output logic           pc_redirect,
    output unit_id_t       out_unit_id,
    output quad_t          out_rt_value,
    output logic           out_wrt_en,
    output reg_addr_t      out_rt_address,
    output latency_t       out_latency
);

    opcode_t   op_q;
    quad_t     ra_q;
    quad_t     rb_q;
    quad_t     rc_q;
    reg_addr_t rt_address_q;
    imm7_t     i7_q;
    imm16_t    i16_q;
    word_t     pc_q;
    unit_id_t  unit_id;
    logic      wrt_en;
    latency_t  unit_latency;
    quad_t     permute_result;
    quad_t     link_result;
    quad_t     rt_value;

    issue_stage i_issue_stage (
        .clock        (clock),
        .reset        (reset),
        .op_code      (op_code),
        .ra           (ra),
        .rb           (rb),
        .rc           (rc),
        .rt_address   (rt_address),
        .i7           (i7),
        .i16          (i16),
        .pc_input     (pc_input),
        .op_q         (op_q),
        .ra_q         (ra_q),
        .rb_q         (rb_q),
        .rc_q         (rc_q),
        .rt_address_q (rt_address_q),
        .i7_q         (i7_q),
        .i16_q        (i16_q),
        .pc_q         (pc_q),
        .unit_id      (unit_id),
        .wrt_en       (wrt_en),
        .unit_latency (unit_latency)
    );

    permute_unit i_permute_unit (
        .op_q           (op_q),
        .ra_q           (ra_q),
        .rb_q           (rb_q),
        .i7_q           (i7_q),
        .permute_result (permute_result)
    );

    branch_unit i_branch_unit (
        .op_q        (op_q),
        .rc_q        (rc_q),
        .i16_q       (i16_q),
        .pc_q        (pc_q),
        .pc_output   (pc_output),
        .pc_redirect (pc_redirect),
        .link_result (link_result)
    );

    // bubbles carry a zero value
    always_comb
    begin
        case (unit_id)
            UNIT_PERMUTE: rt_value = permute_result;
            UNIT_BRANCH:  rt_value = link_result;
            default:      rt_value = '0;
        endcase
    end

    result_pipe #(
        .unit_id_type (unit_id_t),
        .latency_type (latency_t)
    ) i_result_pipe (
        .clock          (clock),
        .reset          (reset),
        .in_unit_id     (unit_id),
        .in_rt_value    (rt_value),
        .in_wrt_en      (wrt_en),
        .in_rt_address  (rt_address_q),
        .in_latency     (unit_latency),
        .out_unit_id    (out_unit_id),
        .out_rt_value   (out_rt_value),
        .out_wrt_en     (out_wrt_en),
        .out_rt_address (out_rt_address),
        .out_latency    (out_latency)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // reset held for two rising edges
    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* verification/tb_odd_pipe.sv */
`default_nettype none

module tb_odd_pipe
    import spu_isa_pkg::*;
    import odd_pipe_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20;
    // falling edges from driving an instruction to seeing its record
    localparam int ISSUE_TO_RECORD = 8;

    logic      clock;
    logic      reset;
    opcode_t   op_code;
    quad_t     ra;
    quad_t     rb;
    quad_t     rc;
    reg_addr_t rt_address;
    imm7_t     i7;
    imm16_t    i16;
    word_t     pc_input;
    word_t     pc_output;
    logic      pc_redirect;
    unit_id_t  out_unit_id;
    quad_t     out_rt_value;
    logic      out_wrt_en;
    reg_addr_t out_rt_address;
    latency_t  out_latency;

    word_t     seen_pc;
    logic      seen_redirect;
    int        seen_cycles;
    reg_addr_t next_tag;

    opcode_t permute_ops [10] = '{
        SHIFT_LEFT_QUADWORD_BY_BITS, SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE,
        SHIFT_LEFT_QUADWORD_BY_BYTES, SHIFT_LEFT_QUADWORD_BY_BYTES_IMMEDIATE,
        SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT, ROTATE_QUADWORD_BY_BITS,
        ROTATE_QUADWORD_BY_BITS_IMMEDIATE, ROTATE_QUADWORD_BY_BYTES,
        ROTATE_QUADWORD_BY_BYTES_IMMEDIATE, ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT
    };
    opcode_t gather_ops [3] = '{
        GATHER_BITS_FROM_BYTES, GATHER_BITS_FROM_HALFWORDS, GATHER_BITS_FROM_WORDS
    };
    opcode_t jump_ops [4] = '{
        BRANCH_RELATIVE, BRANCH_ABSOLUTE,
        BRANCH_RELATIVE_AND_SET_LINK, BRANCH_ABSOLUTE_AND_SET_LINK
    };
    opcode_t cond_ops [4] = '{
        BRANCH_IF_NOT_ZERO_WORD, BRANCH_IF_ZERO_WORD,
        BRANCH_IF_NOT_ZERO_HALFWORD, BRANCH_IF_ZERO_HALFWORD
    };

    tb_clock_gen i_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    odd_pipe i_dut (
        .clock          (clock),
        .reset          (reset),
        .op_code        (op_code),
        .ra             (ra),
        .rb             (rb),
        .rc             (rc),
        .rt_address     (rt_address),
        .i7             (i7),
        .i16            (i16),
        .pc_input       (pc_input),
        .pc_output      (pc_output),
        .pc_redirect    (pc_redirect),
        .out_unit_id    (out_unit_id),
        .out_rt_value   (out_rt_value),
        .out_wrt_en     (out_wrt_en),
        .out_rt_address (out_rt_address),
        .out_latency    (out_latency)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check(input string test_name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
            abort_run("mismatch between expected and actual value");
        end
    endtask

    function automatic quad_t random_quad();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic word_t random_pc();
        return word_t'($urandom) & LSLR & 32'hFFFF_FFFC;
    endfunction

    function automatic reg_addr_t take_tag();
        next_tag = next_tag + 7'd1;
        return next_tag;
    endfunction

    // bit i of the result takes bit i + n of the source
    function automatic quad_t shift_left(input quad_t a, input int n);
        quad_t r;
        for (int i = 0; i < 128; i++)
            r[i] = (i + n < 128) ? a[i + n] : 1'b0;
        return r;
    endfunction

    function automatic quad_t rotate_left(input quad_t a, input int n);
        quad_t r;
        for (int i = 0; i < 128; i++)
            r[i] = a[(i + n) % 128];
        return r;
    endfunction

    // element lsbs packed at the low end of the preferred word, element 0 first
    function automatic quad_t gather_lsbs(input quad_t a, input int elem_bits);
        quad_t r;
        int    count;
        r = '0;
        count = 128 / elem_bits;
        for (int j = 0; j < count; j++)
            r[32 - count + j] = a[(j + 1) * elem_bits - 1];
        return r;
    endfunction

    function automatic quad_t expected_permute(input opcode_t op, input quad_t a,
                                               input quad_t b, input imm7_t imm);
        case (op)
            SHIFT_LEFT_QUADWORD_BY_BITS:
                return shift_left(a, int'(b[29:31]));
            SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE:
                return shift_left(a, int'(imm[4:6]));
            SHIFT_LEFT_QUADWORD_BY_BYTES:
                return shift_left(a, int'(b[27:31]) * 8);
            SHIFT_LEFT_QUADWORD_BY_BYTES_IMMEDIATE:
                return shift_left(a, int'(imm[2:6]) * 8);
            SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT:
                return shift_left(a, int'(b[24:28]) * 8);
            ROTATE_QUADWORD_BY_BITS:
                return rotate_left(a, int'(b[29:31]));
            ROTATE_QUADWORD_BY_BITS_IMMEDIATE:
                return rotate_left(a, int'(imm[4:6]));
            ROTATE_QUADWORD_BY_BYTES:
                return rotate_left(a, int'(b[28:31]) * 8);
            ROTATE_QUADWORD_BY_BYTES_IMMEDIATE:
                return rotate_left(a, int'(imm[3:6]) * 8);
            ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT:
                return rotate_left(a, int'(b[24:28]) * 8);
            GATHER_BITS_FROM_BYTES:
                return gather_lsbs(a, 8);
            GATHER_BITS_FROM_HALFWORDS:
                return gather_lsbs(a, 16);
            GATHER_BITS_FROM_WORDS:
                return gather_lsbs(a, 32);
            default:
                return '0;
        endcase
    endfunction

    function automatic word_t masked_pc(input word_t value);
        return value & LSLR & 32'hFFFF_FFFC;
    endfunction

    // word offset, sign extended
    function automatic word_t branch_offset(input imm16_t imm);
        int off;
        off = int'($signed(imm)) * 4;
        return word_t'(off);
    endfunction

    task automatic issue(input opcode_t op, input quad_t a, input quad_t b, input quad_t c,
                         input imm7_t imm7, input imm16_t imm16, input word_t pc,
                         input reg_addr_t tag);
        @(negedge clock);
        op_code    = op;
        ra         = a;
        rb         = b;
        rc         = c;
        i7         = imm7;
        i16        = imm16;
        pc_input   = pc;
        rt_address = tag;
    endtask

    task automatic drive_bubble();
        op_code    = NO_OPERATION_LOAD;
        rt_address = '0;
    endtask

    task automatic wait_for_tag(input reg_addr_t tag, output int cycles);
        cycles = 0;
        for (int n = 0; n < TIMEOUT_CYCLES; n++)
        begin
            @(negedge clock);
            cycles++;
            if (out_rt_address === tag)
                break;
        end
        if (out_rt_address !== tag)
            abort_run($sformatf("result with tag %0d never emerged from the pipe", tag));
    endtask

    task automatic execute(input opcode_t op, input quad_t a, input quad_t b, input quad_t c,
                           input imm7_t imm7, input imm16_t imm16, input word_t pc,
                           input reg_addr_t tag);
        int cycles;
        issue(op, a, b, c, imm7, imm16, pc, tag);
        @(negedge clock);
        seen_pc       = pc_output;
        seen_redirect = pc_redirect;
        drive_bubble();
        wait_for_tag(tag, cycles);
        seen_cycles = cycles + 1;
    endtask

    task automatic test_reset();
        for (int n = 0; n < TIMEOUT_CYCLES && reset; n++)
            @(negedge clock);
        if (reset)
            abort_run("reset was never released");
        @(negedge clock);
        check("reset wrt_en", 128'(1'b0), 128'(out_wrt_en));
        check("reset unit_id", 128'(UNIT_NONE), 128'(out_unit_id));
        check("reset pc_redirect", 128'(1'b0), 128'(pc_redirect));
    endtask

    task automatic test_permutes(input string group, input opcode_t op);
        quad_t     a;
        quad_t     b;
        imm7_t     imm;
        reg_addr_t tag;
        string     name;
        name = $sformatf("%s %s", group, op.name());
        for (int n = 0; n < 2; n++)
        begin
            a   = random_quad();
            b   = random_quad();
            imm = imm7_t'($urandom);
            tag = take_tag();
            execute(op, a, b, random_quad(), imm, '0, '0, tag);
            check(name, expected_permute(op, a, b, imm), out_rt_value);
            check({name, " unit"}, 128'(UNIT_PERMUTE), 128'(out_unit_id));
            check({name, " latency"}, 128'(PERMUTE_LATENCY), 128'(out_latency));
            check({name, " wrt_en"}, 128'(1'b1), 128'(out_wrt_en));
            check({name, " cycles"}, 128'(ISSUE_TO_RECORD), 128'(seen_cycles));
            check({name, " redirect"}, 128'(1'b0), 128'(seen_redirect));
        end
    endtask

    task automatic test_unconditional_branches();
        word_t  pc;
        imm16_t imm;
        logic   link;
        word_t  target;
        string  name;
        foreach (jump_ops[k])
        begin
            pc   = random_pc();
            imm  = imm16_t'($urandom);
            name = jump_ops[k].name();
            link = (jump_ops[k] == BRANCH_RELATIVE_AND_SET_LINK) ||
                   (jump_ops[k] == BRANCH_ABSOLUTE_AND_SET_LINK);
            if ((jump_ops[k] == BRANCH_ABSOLUTE) || (jump_ops[k] == BRANCH_ABSOLUTE_AND_SET_LINK))
                target = masked_pc(branch_offset(imm));
            else
                target = masked_pc(pc + branch_offset(imm));
            execute(jump_ops[k], random_quad(), random_quad(), random_quad(), '0, imm, pc,
                    take_tag());
            check({name, " pc_output"}, 128'(target), 128'(seen_pc));
            check({name, " pc_redirect"}, 128'(1'b1), 128'(seen_redirect));
            check({name, " unit"}, 128'(UNIT_BRANCH), 128'(out_unit_id));
            check({name, " latency"}, 128'(BRANCH_LATENCY), 128'(out_latency));
            check({name, " wrt_en"}, 128'(link), 128'(out_wrt_en));
            if (link)
                check({name, " link"}, {masked_pc(pc + 32'd4), 96'd0}, out_rt_value);
        end
    endtask

    task automatic test_conditional_branches();
        word_t  pc;
        imm16_t imm;
        quad_t  c;
        logic   zero_form;
        logic   half_form;
        logic   taken;
        word_t  expected;
        string  name;
        foreach (cond_ops[k])
        begin
            zero_form = (cond_ops[k] == BRANCH_IF_ZERO_WORD) ||
                        (cond_ops[k] == BRANCH_IF_ZERO_HALFWORD);
            half_form = (cond_ops[k] == BRANCH_IF_NOT_ZERO_HALFWORD) ||
                        (cond_ops[k] == BRANCH_IF_ZERO_HALFWORD);
            for (int is_zero = 0; is_zero < 2; is_zero++)
            begin
                pc  = random_pc();
                imm = imm16_t'($urandom);
                c   = random_quad();
                name = $sformatf("%s rc zero %0d", cond_ops[k].name(), is_zero);
                if (is_zero == 1)
                begin
                    if (half_form)
                        c[16:31] = '0;
                    else
                        c[0:31] = '0;
                end
                else if (half_form)
                    c[31] = 1'b1;
                else
                begin
                    // nonzero only in the upper halfword, so a halfword test would see zero
                    c[0]     = 1'b1;
                    c[16:31] = '0;
                end
                taken    = zero_form ? (is_zero == 1) : (is_zero == 0);
                expected = taken ? masked_pc(pc + branch_offset(imm)) : masked_pc(pc + 32'd4);
                execute(cond_ops[k], random_quad(), random_quad(), c, '0, imm, pc, take_tag());
                check({name, " pc_output"}, 128'(expected), 128'(seen_pc));
                check({name, " pc_redirect"}, 128'(1'b1), 128'(seen_redirect));
                check({name, " unit"}, 128'(UNIT_BRANCH), 128'(out_unit_id));
                check({name, " wrt_en"}, 128'(1'b0), 128'(out_wrt_en));
            end
        end
    endtask

    task automatic test_back_to_back();
        opcode_t   ops [6];
        reg_addr_t tags [6];
        quad_t     values [6];
        quad_t     a;
        quad_t     b;
        imm7_t     imm;
        word_t     pc;
        int        cycles;
        ops = '{SHIFT_LEFT_QUADWORD_BY_BITS, NO_OPERATION_LOAD, ROTATE_QUADWORD_BY_BYTES_IMMEDIATE,
                BRANCH_RELATIVE_AND_SET_LINK, NO_OPERATION_LOAD, GATHER_BITS_FROM_WORDS};
        for (int k = 0; k < 6; k++)
        begin
            a       = random_quad();
            b       = random_quad();
            imm     = imm7_t'($urandom);
            pc      = random_pc();
            tags[k] = take_tag();
            if (ops[k] == BRANCH_RELATIVE_AND_SET_LINK)
                values[k] = {masked_pc(pc + 32'd4), 96'd0};
            else
                values[k] = expected_permute(ops[k], a, b, imm);
            issue(ops[k], a, b, random_quad(), imm, imm16_t'($urandom), pc, tags[k]);
        end
        @(negedge clock);
        drive_bubble();
        wait_for_tag(tags[0], cycles);
        // one record per cycle, in issue order
        for (int k = 0; k < 6; k++)
        begin
            if (k > 0)
                @(negedge clock);
            check($sformatf("back to back slot %0d tag", k), 128'(tags[k]),
                  128'(out_rt_address));
            check($sformatf("back to back slot %0d wrt_en", k),
                  128'(ops[k] != NO_OPERATION_LOAD), 128'(out_wrt_en));
            if (ops[k] != NO_OPERATION_LOAD)
                check($sformatf("back to back slot %0d value", k), values[k], out_rt_value);
        end
    endtask

    initial
    begin
        void'($urandom(32'h2e1d_45d1));
        op_code    = NO_OPERATION_LOAD;
        ra         = '0;
        rb         = '0;
        rc         = '0;
        rt_address = '0;
        i7         = '0;
        i16        = '0;
        pc_input   = '0;
        next_tag   = '0;

        test_reset();
        foreach (permute_ops[k])
            test_permutes("shift", permute_ops[k]);
        foreach (gather_ops[k])
            test_permutes("gather", gather_ops[k]);
        test_unconditional_branches();
        test_conditional_branches();
        test_back_to_back();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/spu_isa_pkg.sv
design/odd_pipe_pkg.sv
design/issue_stage.sv
design/permute_unit.sv
design/branch_unit.sv
design/result_pipe.sv
design/odd_pipe.sv
verification/tb_clock_gen.sv
verification/tb_odd_pipe.sv

/* Makefile */
TOP = tb_odd_pipe

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f sim.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
